// File: binarize.f
win_pkg.sv
scan_ctrl.sv
line_buffer.sv
window_sum.sv
binarize_top.sv
tb_clk_gen.sv
binarize_chk.sv
binarize_tb.sv

// File: binarize_chk.sv
`timescale 1ns/1ps

module binarize_chk (
    input logic          clk,
    input logic          rst,
    input logic          i_accept,
    input logic          i_out_valid,
    input logic          i_bin,
    input win_pkg::sum_t i_sum,
    input win_pkg::pix_t i_center
);
    import win_pkg::*;

    localparam sum_t SUM_MAX = sum_t'(WIN * WIN * 255);
    localparam int LATENCY = 7;

    int assert_fails = 0;

    a_reset_quiet: assert property (
        @(posedge clk) (rst || $past(rst)) |=> !i_out_valid
    ) else begin
        $error("o_valid high during reset or in the cycle after it");
        assert_fails = assert_fails + 1;
    end

    a_sum_range: assert property (
        @(posedge clk) disable iff (rst) i_out_valid |-> (i_sum <= SUM_MAX)
    ) else begin
        $error("o_sum above the full window maximum");
        assert_fails = assert_fails + 1;
    end

    // dark center can never beat the mean
    a_dark_center: assert property (
        @(posedge clk) disable iff (rst) (i_out_valid && i_center == '0) |-> !i_bin
    ) else begin
        $error("o_bin set with a zero center pixel");
        assert_fails = assert_fails + 1;
    end

    a_latency: assert property (
        @(posedge clk) disable iff (rst) i_out_valid == $past(i_accept, LATENCY)
    ) else begin
        $error("o_valid does not follow an accepted pixel by 7 cycles");
        assert_fails = assert_fails + 1;
    end

endmodule

// File: binarize_tb.sv
`timescale 1ns/1ps

module binarize_tb;
    import win_pkg::*;

    localparam int COLS = 32;
    localparam int ROWS = 16;
    localparam int CLK_PERIOD = 10;
    localparam int LATENCY = 7;
    localparam int BOGUS = 10;
    localparam int DRAIN_LIMIT = 50;
    // five full frames and the stray strobes with room for gaps
    localparam int TOTAL_PIX = 5 * COLS * ROWS + BOGUS;
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_PIX + 500;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    localparam int SRC_FLAT = 0;
    localparam int SRC_RANDOM = 1;
    localparam int SRC_BRIGHT = 2;
    localparam int SRC_DARK = 3;

    logic clk;
    logic rst;
    pix_t i_pix;
    logic i_valid;
    logic i_sof;
    logic o_valid;
    logic o_bin;
    sum_t o_sum;
    pix_t o_center;

    int          errors = 0;
    int          cycle_cnt = 0;
    logic [31:0] lfsr = 32'd73385;
    int          frame [ROWS][COLS];
    int          exp_sum_q [$];
    int          exp_ctr_q [$];
    int          exp_bin_q [$];
    int          stamp_q [$];

    tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk_gen (.o_clk(clk));

    binarize_top uut (
        .clk(clk),
        .rst(rst),
        .i_pix(i_pix),
        .i_valid(i_valid),
        .i_sof(i_sof),
        .o_valid(o_valid),
        .o_bin(o_bin),
        .o_sum(o_sum),
        .o_center(o_center)
    );

    bind binarize_top binarize_chk u_chk (
        .clk(clk),
        .rst(rst),
        .i_accept(accept),
        .i_out_valid(o_valid),
        .i_bin(o_bin),
        .i_sum(o_sum),
        .i_center(o_center)
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    function automatic pix_t make_pixel(input int src);
        case (src)
            SRC_FLAT: return 8'd100;
            SRC_BRIGHT: return pix_t'(128 + rand_bits(7));
            SRC_DARK: return pix_t'(rand_bits(6));
            default: return pix_t'(rand_bits(PIX_W));
        endcase
    endfunction

    // zero padded 13x13 window ending at (r,c) with its center 6 up and 6 left
    task automatic push_expected(input int r, input int c);
        int sum;
        int ctr;
        sum = 0;
        for (int rr = r - (WIN - 1); rr <= r; rr++) begin
            for (int cc = c - (WIN - 1); cc <= c; cc++) begin
                if (rr >= 0 && cc >= 0) begin
                    sum = sum + frame[rr][cc];
                end
            end
        end
        ctr = (r >= HALF && c >= HALF) ? frame[r-HALF][c-HALF] : 0;
        exp_sum_q.push_back(sum);
        exp_ctr_q.push_back(ctr);
        exp_bin_q.push_back((ctr * WIN * WIN > sum) ? 1 : 0);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            i_valid = 1'b0;
            i_sof = 1'b0;
        end
    endtask

    task automatic send_frame(input int src, input bit gaps);
        pix_t pix;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                frame[r][c] = 0;
            end
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                pix = make_pixel(src);
                frame[r][c] = int'(pix);
                push_expected(r, c);
                @(negedge clk);
                i_pix = pix;
                i_valid = 1'b1;
                i_sof = (r == 0 && c == 0);
                stamp_q.push_back(cycle_cnt);
                if (gaps && rand_bits(1) == 1) begin
                    drive_idle(1);
                end
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_sum_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_sum_q.size() != 0) begin
            $display("missing outputs: %0d results never appeared", exp_sum_q.size());
            errors++;
            exp_sum_q.delete();
            exp_ctr_q.delete();
            exp_bin_q.delete();
            stamp_q.delete();
        end
    endtask

    task automatic reset_state_quiet();
        repeat (20) begin
            @(negedge clk);
            i_valid = 1'b0;
            i_sof = 1'b0;
            if (o_valid !== 1'b0) begin
                $display("CHECK FAILED o_valid expected %h got %h", 1'b0, o_valid);
                errors++;
            end
        end
    endtask

    task automatic flat_frame();
        send_frame(SRC_FLAT, 1'b0);
        drive_idle(1);
        wait_drain();
    endtask

    task automatic random_frame_gaps();
        send_frame(SRC_RANDOM, 1'b1);
        drive_idle(1);
        wait_drain();
    endtask

    // idle controller ignores strobes until a frame start
    task automatic strobes_before_sof();
        repeat (BOGUS) begin
            @(negedge clk);
            i_pix = pix_t'(rand_bits(PIX_W));
            i_valid = 1'b1;
            i_sof = 1'b0;
        end
        drive_idle(20);
        send_frame(SRC_RANDOM, 1'b0);
        drive_idle(1);
        wait_drain();
    endtask

    task automatic back_to_back_frames();
        send_frame(SRC_BRIGHT, 1'b0);
        send_frame(SRC_DARK, 1'b0);
        drive_idle(1);
        wait_drain();
    endtask

    always @(negedge clk) begin : monitor
        int e_sum;
        int e_ctr;
        int e_bin;
        int stamp;
        if (!rst && o_valid === 1'b1) begin
            if (exp_sum_q.size() == 0) begin
                $display("unexpected output: o_valid high with no pixel pending");
                errors++;
            end else begin
                e_sum = exp_sum_q.pop_front();
                e_ctr = exp_ctr_q.pop_front();
                e_bin = exp_bin_q.pop_front();
                stamp = stamp_q.pop_front();
                if (o_sum !== sum_t'(e_sum)) begin
                    $display("CHECK FAILED o_sum expected %h got %h", sum_t'(e_sum), o_sum);
                    errors++;
                end
                if (o_center !== pix_t'(e_ctr)) begin
                    $display("CHECK FAILED o_center expected %h got %h",
                             pix_t'(e_ctr), o_center);
                    errors++;
                end
                if (o_bin !== e_bin[0]) begin
                    $display("CHECK FAILED o_bin expected %h got %h", e_bin[0], o_bin);
                    errors++;
                end
                if (cycle_cnt - stamp != LATENCY) begin
                    $display("CHECK FAILED o_valid latency expected %h got %h",
                             LATENCY, cycle_cnt - stamp);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        i_pix = '0;
        i_valid = 1'b0;
        i_sof = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state_quiet();
        flat_frame();
        random_frame_gaps();
        strobes_before_sof();
        back_to_back_frames();

        $display("errors: %0d  assertion failures: %0d", errors, uut.u_chk.assert_fails);
        if (errors == 0 && uut.u_chk.assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: binarize_top.sv
`timescale 1ns/1ps

module binarize_top #(
    parameter int COLS = 32,
    parameter int ROWS = 16
) (
    input  logic          clk,
    input  logic          rst,
    input  win_pkg::pix_t i_pix,
    input  logic          i_valid,
    input  logic          i_sof,
    output logic          o_valid,
    output logic          o_bin,
    output win_pkg::sum_t o_sum,
    output win_pkg::pix_t o_center
);
    import win_pkg::*;

    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    // controller to line buffer
    logic             accept;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             ld;
    logic             sub;

    // line buffer to window sum
    pix_t             tap [WIN];
    logic             lb_valid;
    logic             lb_ld;
    logic             lb_sub;
    logic [COL_W-1:0] lb_col;
    logic [ROW_W-1:0] lb_row;

    scan_ctrl #(
        .COLS(COLS),
        .ROWS(ROWS)
    ) u_scan_ctrl (
        .clk(clk),
        .rst(rst),
        .i_valid(i_valid),
        .i_sof(i_sof),
        .o_accept(accept),
        .o_col(col),
        .o_row(row),
        .o_ld(ld),
        .o_sub(sub)
    );

    line_buffer #(
        .COLS(COLS),
        .ROWS(ROWS)
    ) u_line_buffer (
        .clk(clk),
        .rst(rst),
        .i_pix(i_pix),
        .i_accept(accept),
        .i_col(col),
        .i_row(row),
        .i_ld(ld),
        .i_sub(sub),
        .o_tap0(tap[0]),
        .o_tap1(tap[1]),
        .o_tap2(tap[2]),
        .o_tap3(tap[3]),
        .o_tap4(tap[4]),
        .o_tap5(tap[5]),
        .o_tap6(tap[6]),
        .o_tap7(tap[7]),
        .o_tap8(tap[8]),
        .o_tap9(tap[9]),
        .o_tap10(tap[10]),
        .o_tap11(tap[11]),
        .o_tap12(tap[12]),
        .o_valid(lb_valid),
        .o_ld(lb_ld),
        .o_sub(lb_sub),
        .o_col(lb_col),
        .o_row(lb_row)
    );

    window_sum #(
        .COLS(COLS),
        .ROWS(ROWS)
    ) u_window_sum (
        .clk(clk),
        .rst(rst),
        .i_tap0(tap[0]),
        .i_tap1(tap[1]),
        .i_tap2(tap[2]),
        .i_tap3(tap[3]),
        .i_tap4(tap[4]),
        .i_tap5(tap[5]),
        .i_tap6(tap[6]),
        .i_tap7(tap[7]),
        .i_tap8(tap[8]),
        .i_tap9(tap[9]),
        .i_tap10(tap[10]),
        .i_tap11(tap[11]),
        .i_tap12(tap[12]),
        .i_valid(lb_valid),
        .i_ld(lb_ld),
        .i_sub(lb_sub),
        .i_col(lb_col),
        .i_row(lb_row),
        .o_valid(o_valid),
        .o_bin(o_bin),
        .o_sum(o_sum),
        .o_center(o_center)
    );

endmodule

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int COLS = 32,
    parameter int ROWS = 16,
    localparam int COL_W = $clog2(COLS),
    localparam int ROW_W = $clog2(ROWS)
) (
    input  logic             clk,
    input  logic             rst,
    input  win_pkg::pix_t    i_pix,
    input  logic             i_accept,
    input  logic [COL_W-1:0] i_col,
    input  logic [ROW_W-1:0] i_row,
    input  logic             i_ld,
    input  logic             i_sub,
    output win_pkg::pix_t    o_tap0,
    output win_pkg::pix_t    o_tap1,
    output win_pkg::pix_t    o_tap2,
    output win_pkg::pix_t    o_tap3,
    output win_pkg::pix_t    o_tap4,
    output win_pkg::pix_t    o_tap5,
    output win_pkg::pix_t    o_tap6,
    output win_pkg::pix_t    o_tap7,
    output win_pkg::pix_t    o_tap8,
    output win_pkg::pix_t    o_tap9,
    output win_pkg::pix_t    o_tap10,
    output win_pkg::pix_t    o_tap11,
    output win_pkg::pix_t    o_tap12,
    output logic             o_valid,
    output logic             o_ld,
    output logic             o_sub,
    output logic [COL_W-1:0] o_col,
    output logic [ROW_W-1:0] o_row
);
    import win_pkg::*;

    // memory k holds the row k+1 above
    pix_t mem [WIN-1][COLS];
    pix_t tap_c [WIN];

    // rows above row 0 read as zero
    always_comb begin
        tap_c[0] = i_pix;
        for (int k = 1; k < WIN; k++) begin
            tap_c[k] = (k > int'(i_row)) ? '0 : mem[k-1][i_col];
        end
    end

    // read before write shifts the column down one row
    always_ff @(posedge clk) begin
        if (i_accept) begin
            for (int k = 0; k < WIN - 1; k++) begin
                mem[k][i_col] <= tap_c[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        o_tap0 <= tap_c[0];
        o_tap1 <= tap_c[1];
        o_tap2 <= tap_c[2];
        o_tap3 <= tap_c[3];
        o_tap4 <= tap_c[4];
        o_tap5 <= tap_c[5];
        o_tap6 <= tap_c[6];
        o_tap7 <= tap_c[7];
        o_tap8 <= tap_c[8];
        o_tap9 <= tap_c[9];
        o_tap10 <= tap_c[10];
        o_tap11 <= tap_c[11];
        o_tap12 <= tap_c[12];
        o_ld <= i_ld;
        o_sub <= i_sub;
        o_col <= i_col;
        o_row <= i_row;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_accept;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module binarize_tb -f binarize.f \
    --Mdir obj_dir -o binarize_sim \
    || exit 1

./obj_dir/binarize_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "Testbench passed" sim.log && echo "simulation ok" || { echo "simulation bad"; exit 1; }

// File: scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl #(
    parameter int COLS = 32,
    parameter int ROWS = 16,
    localparam int COL_W = $clog2(COLS),
    localparam int ROW_W = $clog2(ROWS)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_valid,
    input  logic             i_sof,
    output logic             o_accept,
    output logic [COL_W-1:0] o_col,
    output logic [ROW_W-1:0] o_row,
    output logic             o_ld,
    output logic             o_sub
);
    import win_pkg::*;

    scan_state_t      state;
    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             last_col;
    logic             last_row;

    // sof restarts at (0,0) whatever the state
    always_comb begin
        o_accept = i_valid && (i_sof || state == ST_SCAN);
        o_col = i_sof ? '0 : col_q;
        o_row = i_sof ? '0 : row_q;
        last_col = (int'(o_col) == COLS - 1);
        last_row = (int'(o_row) == ROWS - 1);
    end

    // running sum controls
    assign o_ld = (o_col == '0);
    assign o_sub = (int'(o_col) >= WIN);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            col_q <= '0;
            row_q <= '0;
        end else if (o_accept) begin
            if (last_col && last_row) begin
                // frame done, wait for next sof
                state <= ST_IDLE;
                col_q <= '0;
                row_q <= '0;
            end else if (last_col) begin
                state <= ST_SCAN;
                col_q <= '0;
                row_q <= o_row + 1'b1;
            end else begin
                state <= ST_SCAN;
                col_q <= o_col + 1'b1;
                row_q <= o_row;
            end
        end
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD = 10
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// File: win_pkg.sv
package win_pkg;

    // pixel and window geometry
    localparam int PIX_W = 8;
    localparam int WIN = 13;
    localparam int HALF = 6;

    // 13 x 255 needs 12 bits
    localparam int COLSUM_W = 12;

    // 169 x 255 = 43095 needs 16 bits
    localparam int SUM_W = 16;

    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [SUM_W-1:0] sum_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_SCAN = 1'b1
    } scan_state_t;

endpackage

// File: window_sum.sv
`timescale 1ns/1ps

module window_sum #(
    parameter int COLS = 32,
    parameter int ROWS = 16,
    localparam int COL_W = $clog2(COLS),
    localparam int ROW_W = $clog2(ROWS)
) (
    input  logic             clk,
    input  logic             rst,
    input  win_pkg::pix_t    i_tap0,
    input  win_pkg::pix_t    i_tap1,
    input  win_pkg::pix_t    i_tap2,
    input  win_pkg::pix_t    i_tap3,
    input  win_pkg::pix_t    i_tap4,
    input  win_pkg::pix_t    i_tap5,
    input  win_pkg::pix_t    i_tap6,
    input  win_pkg::pix_t    i_tap7,
    input  win_pkg::pix_t    i_tap8,
    input  win_pkg::pix_t    i_tap9,
    input  win_pkg::pix_t    i_tap10,
    input  win_pkg::pix_t    i_tap11,
    input  win_pkg::pix_t    i_tap12,
    input  logic             i_valid,
    input  logic             i_ld,
    input  logic             i_sub,
    input  logic [COL_W-1:0] i_col,
    input  logic [ROW_W-1:0] i_row,
    output logic             o_valid,
    output logic             o_bin,
    output win_pkg::sum_t    o_sum,
    output win_pkg::pix_t    o_center
);
    import win_pkg::*;

    // adder tree depth
    localparam int TREE = 4;
    localparam sum_t AREA = sum_t'(WIN * WIN);

    logic [PIX_W:0]      s1 [6];
    pix_t                s1_odd;
    logic [PIX_W+1:0]    s2 [3];
    pix_t                s2_odd;
    logic [PIX_W+2:0]    s3 [2];
    logic [COLSUM_W-1:0] colsum;

    logic [TREE-1:0] v_sr;
    logic [TREE-1:0] ld_sr;
    logic [TREE-1:0] sub_sr;
    logic [TREE-1:0] ok_sr;
    pix_t            ctr_sr [TREE];
    logic            ctr_ok;

    logic [COLSUM_W-1:0] hist [WIN];
    pix_t                ctr_dly [HALF];
    sum_t                run_q;
    sum_t                sub_term;
    sum_t                ctr_scaled;
    pix_t                center_q;
    logic                v5;

    // 13 -> 7 -> 4 -> 2 -> 1, odd tap joins at level 3
    always_ff @(posedge clk) begin
        s1[0] <= {1'b0, i_tap0} + {1'b0, i_tap1};
        s1[1] <= {1'b0, i_tap2} + {1'b0, i_tap3};
        s1[2] <= {1'b0, i_tap4} + {1'b0, i_tap5};
        s1[3] <= {1'b0, i_tap6} + {1'b0, i_tap7};
        s1[4] <= {1'b0, i_tap8} + {1'b0, i_tap9};
        s1[5] <= {1'b0, i_tap10} + {1'b0, i_tap11};
        s1_odd <= i_tap12;
        for (int i = 0; i < 3; i++) begin
            s2[i] <= {1'b0, s1[2*i]} + {1'b0, s1[2*i+1]};
        end
        s2_odd <= s1_odd;
        s3[0] <= {1'b0, s2[0]} + {1'b0, s2[1]};
        s3[1] <= {1'b0, s2[2]} + {3'b000, s2_odd};
        colsum <= {1'b0, s3[0]} + {1'b0, s3[1]};
    end

    // center exists only from row 6 and col 6 on
    assign ctr_ok = (int'(i_row) >= HALF) && (int'(i_col) >= HALF);

    // sideband alongside the tree
    always_ff @(posedge clk) begin
        if (rst) begin
            v_sr <= '0;
        end else begin
            v_sr <= {v_sr[TREE-2:0], i_valid};
        end
    end

    always_ff @(posedge clk) begin
        ld_sr <= {ld_sr[TREE-2:0], i_ld};
        sub_sr <= {sub_sr[TREE-2:0], i_sub};
        ok_sr <= {ok_sr[TREE-2:0], ctr_ok};
        ctr_sr[0] <= i_tap6;
        for (int i = 1; i < TREE; i++) begin
            ctr_sr[i] <= ctr_sr[i-1];
        end
    end

    // drop the column leaving the window
    assign sub_term = sub_sr[TREE-1] ? (~sum_t'(hist[WIN-1])) + sum_t'(1) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            v5 <= 1'b0;
            run_q <= '0;
            center_q <= '0;
            for (int k = 0; k < WIN; k++) begin
                hist[k] <= '0;
            end
            for (int k = 0; k < HALF; k++) begin
                ctr_dly[k] <= '0;
            end
        end else begin
            v5 <= v_sr[TREE-1];
            if (v_sr[TREE-1]) begin
                hist[0] <= colsum;
                for (int k = 1; k < WIN; k++) begin
                    hist[k] <= hist[k-1];
                end
                ctr_dly[0] <= ctr_sr[TREE-1];
                for (int k = 1; k < HALF; k++) begin
                    ctr_dly[k] <= ctr_dly[k-1];
                end
                if (ld_sr[TREE-1]) begin
                    run_q <= sum_t'(colsum);
                end else begin
                    run_q <= run_q + sum_t'(colsum) + sub_term;
                end
                // six valid columns back
                center_q <= ok_sr[TREE-1] ? ctr_dly[HALF-1] : '0;
            end
        end
    end

    // brighter than local mean
    assign ctr_scaled = sum_t'(center_q) * AREA;

    always_ff @(posedge clk) begin
        o_sum <= run_q;
        o_center <= center_q;
        o_bin <= (ctr_scaled > run_q);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= v5;
        end
    end

endmodule
